// ==== sim.f ====
hw/uart_echo_pkg.sv
hw/uart_rx.sv
hw/uart_tx.sv
hw/byte_fifo.sv
hw/uart_echo_top.sv
verification/tb_uart_echo.sv

// ==== Bender.yml ====
package:
  name: uart_echo

sources:
  - files:
      - hw/uart_echo_pkg.sv
      - hw/uart_rx.sv
      - hw/uart_tx.sv
      - hw/byte_fifo.sv
      - hw/uart_echo_top.sv
  - target: simulation
    files:
      - verification/tb_uart_echo.sv

// ==== verification/tb_uart_echo.sv ====
// Runs the echo path with a 16-clock bit time; stops at the first failed check, bounded by a cycle limit
`timescale 1ns/10ps

module tb_uart_echo
    import uart_echo_pkg::*;
();

    localparam int CLK_PERIOD = 100;
    localparam int DRV_DLY    = 10;
    localparam int RST_CYC    = 16;
    localparam int BIT_CYC    = 16;
    localparam int FRAME_CYC  = 10 * BIT_CYC;
    localparam int GAP_CYC    = 2 * FRAME_CYC;
    localparam int BURST_LEN  = 20;
    // Single, burst, bad plus good, good after glitch
    localparam int N_FRAMES   = 1 + BURST_LEN + 2 + 1;
    // Five idle gaps plus the short idles around the bad stop bit and the glitch
    localparam int STIM_CYC    = RST_CYC + N_FRAMES * FRAME_CYC + 5 * GAP_CYC + 4 * BIT_CYC;
    localparam int TIMEOUT_CYC = 2 * STIM_CYC;

    logic        i_clk;
    logic        i_rst_n;
    logic        i_uart_rxd;
    logic        o_uart_txd;

    byte_t       expected[$];
    logic        mon_busy;
    int          seed;
    int unsigned cycle_cnt = 0;

    uart_echo_top #(
        .P_CLKS_PER_BIT (BIT_CYC)
    ) uut (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_uart_rxd (i_uart_rxd),
        .o_uart_txd (o_uart_txd)
    );

    initial begin
        i_clk = 1'b0;
        forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
    end

    task automatic report_error(input string msg);
        $display("ERR at %0t ns: %s", $time, msg);
        $display("Test FAILED");
        $fatal(1, "stopped at first error");
    endtask

    // Entered just after a drive point, returns at the next one
    task automatic hold_line(input logic value, input int cycles);
        i_uart_rxd = value;
        repeat (cycles) @(posedge i_clk);
        #DRV_DLY;
    endtask

    task automatic send_frame(input byte_t data, input logic bad_stop);
        if (!bad_stop) begin
            expected.push_back(data);
        end
        hold_line(1'b0, BIT_CYC);
        for (int i = 0; i < DATA_BITS; i++) begin
            hold_line(data[i], BIT_CYC);
        end
        hold_line(!bad_stop, BIT_CYC);
    endtask

    // Low pulse of a quarter bit, then one idle bit
    task automatic send_glitch();
        hold_line(1'b0, BIT_CYC / 4);
        hold_line(1'b1, BIT_CYC);
    endtask

    task automatic wait_drain();
        @(posedge i_clk);
        while (expected.size() != 0 || mon_busy) begin
            @(posedge i_clk);
        end
        #DRV_DLY;
    endtask

    // Three samples 6 clocks apart around mid-bit, all must agree
    task automatic sample_bit(output logic val);
        logic first;
        logic middle;
        logic last;
        first = o_uart_txd;
        repeat (6) @(negedge i_clk);
        middle = o_uart_txd;
        repeat (6) @(negedge i_clk);
        last = o_uart_txd;
        a_bit_steady: assert (first === middle && middle === last)
            else report_error("o_uart_txd changed inside a bit period");
        val = middle;
    endtask

    initial begin : line_monitor
        byte_t exp_byte;
        byte_t got;
        logic  bit_val;
        mon_busy = 1'b0;
        forever begin
            @(negedge i_clk);
            if (o_uart_txd === 1'b0) begin
                mon_busy = 1'b1;
                a_frame_expected: assert (expected.size() != 0)
                    else report_error("frame on o_uart_txd with no byte pending");
                exp_byte = expected.pop_front();
                // First sample lands 6 clocks before the start bit's middle
                @(negedge i_clk);
                sample_bit(bit_val);
                a_start_low: assert (bit_val === 1'b0)
                    else report_error("start bit not low at mid-bit");
                for (int i = 0; i < DATA_BITS; i++) begin
                    repeat (4) @(negedge i_clk);
                    sample_bit(bit_val);
                    got[i] = bit_val;
                end
                repeat (4) @(negedge i_clk);
                sample_bit(bit_val);
                a_stop_high: assert (bit_val === 1'b1)
                    else report_error("stop bit not high at mid-bit");
                a_byte_match: assert (got === exp_byte)
                    else report_error($sformatf("echo 0x%02h, expected 0x%02h", got, exp_byte));
                mon_busy = 1'b0;
            end
        end
    end

    a_reset_idle: assert property (
        @(posedge i_clk) !i_rst_n |=> o_uart_txd
    ) else report_error("o_uart_txd not high during reset");

    a_txd_known: assert property (
        @(posedge i_clk) disable iff (!i_rst_n) !$isunknown(o_uart_txd)
    ) else report_error("o_uart_txd unknown after reset");

    always @(posedge i_clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYC) begin
            $display("Timeout: run did not finish within %0d clock cycles", TIMEOUT_CYC);
            $display("Test FAILED");
            $fatal(1, "timeout");
        end
    end

    initial begin
        int rnd;
        i_rst_n    = 1'b0;
        i_uart_rxd = 1'b1;
        seed       = 47344;
        repeat (RST_CYC) @(posedge i_clk);
        #DRV_DLY;
        i_rst_n = 1'b1;

        // Idle line after reset, nothing may come out
        hold_line(1'b1, GAP_CYC);

        // Single byte, mixed bit pattern
        send_frame(8'hA5, 1'b0);
        wait_drain();
        hold_line(1'b1, GAP_CYC);

        // Burst with no idle between frames
        for (int n = 0; n < BURST_LEN; n++) begin
            rnd = $random(seed);
            send_frame(rnd[DATA_BITS-1:0], 1'b0);
        end
        wait_drain();
        hold_line(1'b1, GAP_CYC);

        // Framing error, line returns high before the good byte
        send_frame(8'h3C, 1'b1);
        hold_line(1'b1, 2 * BIT_CYC);
        send_frame(8'hC3, 1'b0);
        wait_drain();
        hold_line(1'b1, GAP_CYC);

        // False start
        send_glitch();
        send_frame(8'h5A, 1'b0);
        wait_drain();
        hold_line(1'b1, GAP_CYC);

        if (expected.size() == 0 && !mon_busy) begin
            $display("Test OK");
            $finish;
        end else begin
            $display("Echo bytes still pending at the end of the run");
            $display("Test FAILED");
            $fatal(1, "pending bytes");
        end
    end

endmodule

// ==== hw/uart_echo_top.sv ====
// Echoes every good 8N1 byte back out; one shared bit time, no parity, break or flow control
`timescale 1ns/10ps

module uart_echo_top
    import uart_echo_pkg::*;
#(
    parameter int P_CLKS_PER_BIT = CLKS_PER_BIT
) (
    input  logic i_clk,
    input  logic i_rst_n,
    input  logic i_uart_rxd,
    output logic o_uart_txd
);

    logic  rx_valid;
    byte_t rx_data;
    logic  fifo_valid;
    byte_t fifo_data;
    logic  tx_ready;

    // Mid-bit sampling needs at least a few clocks per bit
    if (P_CLKS_PER_BIT < 4) begin : g_bad_bit_time
        $error("P_CLKS_PER_BIT must be 4 or more");
    end

    uart_rx #(
        .P_CLKS_PER_BIT (P_CLKS_PER_BIT)
    ) u_uart_rx (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_uart_rxd (i_uart_rxd),
        .o_rx_valid (rx_valid),
        .o_rx_data  (rx_data)
    );

    // Queue bytes while the transmitter is busy
    byte_fifo u_byte_fifo (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_wr_valid (rx_valid),
        .i_wr_data  (rx_data),
        .o_rd_valid (fifo_valid),
        .o_rd_data  (fifo_data),
        .i_rd_ready (tx_ready)
    );

    uart_tx #(
        .P_CLKS_PER_BIT (P_CLKS_PER_BIT)
    ) u_uart_tx (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_tx_valid (fifo_valid),
        .i_tx_data  (fifo_data),
        .o_tx_ready (tx_ready),
        .o_uart_txd (o_uart_txd)
    );

endmodule

// ==== hw/byte_fifo.sv ====
// Single clock show-ahead FIFO; writes while full are dropped, depth fixed by FIFO_DEPTH
`timescale 1ns/10ps

module byte_fifo
    import uart_echo_pkg::*;
(
    input  logic  i_clk,
    input  logic  i_rst_n,
    input  logic  i_wr_valid,
    input  byte_t i_wr_data,
    output logic  o_rd_valid,
    output byte_t o_rd_data,
    input  logic  i_rd_ready
);

    localparam logic [FIFO_AW:0] FULL_CNT = (FIFO_AW + 1)'(FIFO_DEPTH);

    byte_t              mem [FIFO_DEPTH];
    logic [FIFO_AW-1:0] wr_ptr;
    logic [FIFO_AW-1:0] rd_ptr;
    logic [FIFO_AW:0]   count;
    logic               full;
    logic               wr_en;
    logic               rd_en;

    assign full       = (count == FULL_CNT);
    assign o_rd_valid = (count != '0);
    assign wr_en      = i_wr_valid && !full;
    assign rd_en      = o_rd_valid && i_rd_ready;

    // Oldest byte shows directly on the output
    assign o_rd_data = mem[rd_ptr];

    always_ff @(posedge i_clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= i_wr_data;
        end
    end

    // Pointers wrap naturally at the power-of-two depth
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + FIFO_AW'(1);
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + FIFO_AW'(1);
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            count <= '0;
        end else begin
            case ({wr_en, rd_en})
                2'b10: begin
                    count <= count + (FIFO_AW + 1)'(1);
                end
                2'b01: begin
                    count <= count - (FIFO_AW + 1)'(1);
                end
                default: begin
                    count <= count;
                end
            endcase
        end
    end

    // Receiver has no ready, so a byte landing on a full FIFO is lost
    a_no_overflow: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        i_wr_valid |-> !full
    );

    // Held byte must not change until the transmitter takes it
    a_rd_stable: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        (o_rd_valid && !i_rd_ready) |=> (o_rd_valid && $stable(o_rd_data))
    );

endmodule

// ==== hw/uart_tx.sv ====
// Needs P_CLKS_PER_BIT of 4 or more; fixed 8N1 with no flow control, line idles high
`timescale 1ns/10ps

module uart_tx
    import uart_echo_pkg::*;
#(
    parameter int P_CLKS_PER_BIT = CLKS_PER_BIT
) (
    input  logic  i_clk,
    input  logic  i_rst_n,
    input  logic  i_tx_valid,
    input  byte_t i_tx_data,
    output logic  o_tx_ready,
    output logic  o_uart_txd
);

    localparam logic [BIT_CNT_W-1:0] FULL_BIT = BIT_CNT_W'(P_CLKS_PER_BIT - 1);
    // Start, data and stop bits
    localparam int IDX_W = $clog2(DATA_BITS + 2);
    localparam logic [IDX_W-1:0] STOP_IDX = IDX_W'(DATA_BITS + 1);

    logic                 busy;
    logic                 tx_fire;
    logic                 bit_end;
    logic [BIT_CNT_W-1:0] bit_cnt;
    logic [IDX_W-1:0]     bit_idx;
    logic [DATA_BITS:0]   tx_shift;

    assign o_tx_ready = !busy;
    assign tx_fire    = i_tx_valid && o_tx_ready;
    assign bit_end    = (bit_cnt == FULL_BIT);

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            busy       <= 1'b0;
            bit_cnt    <= '0;
            bit_idx    <= '0;
            o_uart_txd <= 1'b1;
        end else if (tx_fire) begin
            // Start bit goes out the cycle after the transfer
            busy       <= 1'b1;
            bit_cnt    <= '0;
            bit_idx    <= '0;
            o_uart_txd <= 1'b0;
        end else if (busy) begin
            if (bit_end) begin
                bit_cnt <= '0;
                if (bit_idx == STOP_IDX) begin
                    busy <= 1'b0;
                end else begin
                    o_uart_txd <= tx_shift[0];
                    bit_idx    <= bit_idx + IDX_W'(1);
                end
            end else begin
                bit_cnt <= bit_cnt + BIT_CNT_W'(1);
            end
        end
    end

    // Stop bit rides above the data byte
    always_ff @(posedge i_clk) begin
        if (tx_fire) begin
            tx_shift <= {1'b1, i_tx_data};
        end else if (busy && bit_end && bit_idx != STOP_IDX) begin
            tx_shift <= {1'b0, tx_shift[DATA_BITS:1]};
        end
    end

    // Ready only once the stop bit has fully ended
    a_idle_high: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        o_tx_ready |-> o_uart_txd
    );

endmodule

// ==== hw/uart_rx.sv ====
// Needs P_CLKS_PER_BIT of 4 or more; single mid-bit sample per bit, bad frames are dropped silently
`timescale 1ns/10ps

module uart_rx
    import uart_echo_pkg::*;
#(
    parameter int P_CLKS_PER_BIT = CLKS_PER_BIT
) (
    input  logic  i_clk,
    input  logic  i_rst_n,
    input  logic  i_uart_rxd,
    output logic  o_rx_valid,
    output byte_t o_rx_data
);

    localparam logic [BIT_CNT_W-1:0] FULL_BIT = BIT_CNT_W'(P_CLKS_PER_BIT - 1);
    localparam logic [BIT_CNT_W-1:0] HALF_BIT = BIT_CNT_W'(P_CLKS_PER_BIT / 2 - 1);
    localparam int IDX_W = $clog2(DATA_BITS);
    localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(DATA_BITS - 1);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_START,
        ST_DATA,
        ST_STOP
    } rx_state_t;

    rx_state_t            state;
    logic                 rxd_meta;
    logic                 rxd_sync;
    logic                 rxd_prev;
    logic                 start_edge;
    logic [BIT_CNT_W-1:0] bit_cnt;
    logic [IDX_W-1:0]     bit_idx;
    byte_t                rx_shift;

    // Two-flop synchronizer, idle line is high
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            rxd_meta <= 1'b1;
            rxd_sync <= 1'b1;
            rxd_prev <= 1'b1;
        end else begin
            rxd_meta <= i_uart_rxd;
            rxd_sync <= rxd_meta;
            rxd_prev <= rxd_sync;
        end
    end

    assign start_edge = rxd_prev && !rxd_sync;

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            state      <= ST_IDLE;
            bit_cnt    <= '0;
            bit_idx    <= '0;
            o_rx_valid <= 1'b0;
        end else begin
            o_rx_valid <= 1'b0;
            case (state)
                ST_IDLE: begin
                    bit_cnt <= '0;
                    bit_idx <= '0;
                    if (start_edge) begin
                        state <= ST_START;
                    end
                end
                ST_START: begin
                    // Confirm start bit at mid-bit, a high line here was a glitch
                    if (bit_cnt == HALF_BIT) begin
                        bit_cnt <= '0;
                        state   <= rxd_sync ? ST_IDLE : ST_DATA;
                    end else begin
                        bit_cnt <= bit_cnt + BIT_CNT_W'(1);
                    end
                end
                ST_DATA: begin
                    if (bit_cnt == FULL_BIT) begin
                        bit_cnt <= '0;
                        bit_idx <= bit_idx + IDX_W'(1);
                        if (bit_idx == LAST_IDX) begin
                            state <= ST_STOP;
                        end
                    end else begin
                        bit_cnt <= bit_cnt + BIT_CNT_W'(1);
                    end
                end
                ST_STOP: begin
                    // Low stop bit means a framing error, byte is not delivered
                    if (bit_cnt == FULL_BIT) begin
                        bit_cnt    <= '0;
                        o_rx_valid <= rxd_sync;
                        state      <= ST_IDLE;
                    end else begin
                        bit_cnt <= bit_cnt + BIT_CNT_W'(1);
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // Data arrives LSB first
    always_ff @(posedge i_clk) begin
        if (state == ST_DATA && bit_cnt == FULL_BIT) begin
            rx_shift <= {rxd_sync, rx_shift[DATA_BITS-1:1]};
        end
    end

    assign o_rx_data = rx_shift;

    // At most one byte per frame
    a_valid_single: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        o_rx_valid |=> !o_rx_valid
    );

    a_valid_in_reset: assert property (
        @(posedge i_clk)
        !i_rst_n |=> !o_rx_valid
    );

endmodule

// ==== hw/uart_echo_pkg.sv ====
// Constants assume 8N1 framing only; default bit time is 1085 clocks (115200 bps from 125 MHz)
package uart_echo_pkg;

    // Serial frame format
    localparam int DATA_BITS = 8;

    // Bit time at 125 MHz for 115200 bps
    localparam int CLKS_PER_BIT = 1085;

    // Bit timers, any bit time up to 65535 clocks
    localparam int BIT_CNT_W = 16;

    // Echo buffer
    localparam int FIFO_DEPTH = 256;
    localparam int FIFO_AW = 8;

    // One data byte on the serial line
    typedef logic [DATA_BITS-1:0] byte_t;

endpackage
